//--- source/arb_ctrl_settings.svh
`ifndef ARB_CTRL_SETTINGS_SVH
`define ARB_CTRL_SETTINGS_SVH

// ########################################
// Concentrator sizing
// ########################################

// Number of requesters feeding the concentrator
`define ARB_CTRL_PORTS 6

// Width of one read-request word
`define ARB_CTRL_DATA_WIDTH 32

`define ARB_CTRL_IN_DEPTH_BITS 4   // Each input FIFO holds 16 words
`define ARB_CTRL_OUT_DEPTH_BITS 4  // Output FIFO holds 16 tagged words

`endif

//--- source/arb_ctrl_pkg.sv
`default_nettype none

`include "arb_ctrl_settings.svh"

package arb_ctrl_pkg;

  // One read request as written by a requester
  typedef logic [`ARB_CTRL_DATA_WIDTH-1:0] req_word_t;

  typedef logic [$clog2(`ARB_CTRL_PORTS)-1:0] port_idx_t;  // Requester number

  // Request word tagged with its source port for the response path
  typedef struct packed {
    port_idx_t src;
    req_word_t data;
  } tagged_req_t;

endpackage

`default_nettype wire

//--- source/req_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module req_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int depth_bits = 4,
  parameter int almost_full_level = 10,
  parameter int almost_empty_level = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_reg,
  input  wire logic             we,
  input  wire payload_t         din,
  input  wire logic             re,
  output logic                  valid,
  output payload_t              dout,
  output logic [depth_bits:0]   count,
  output logic                  empty,
  output logic                  full,
  output logic                  almost_full,
  output logic                  almost_empty
);

  localparam int depth = 2 ** depth_bits;

  payload_t mem [depth];

  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic wr_accept;
  logic rd_accept;

  // Writes into a full buffer and reads from an empty one are dropped
  assign wr_accept = we && !full;
  assign rd_accept = re && !empty;

  // ########################################
  // Storage
  // ########################################

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      mem[wr_ptr] <= din;
    end
    if (rd_accept) begin
      dout <= mem[rd_ptr];  // Read data shows up one cycle after re
    end
  end

  // ########################################
  // Pointers and occupancy
  // ########################################

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= rd_accept;
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at the buffer end
      end
      if (rd_accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_accept, rd_accept})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags follow the registered count, so they change the cycle after a write or read
  assign empty = (count == '0);
  assign full = (count == (depth_bits + 1)'(depth));
  assign almost_full = (count >= (depth_bits + 1)'(almost_full_level));
  assign almost_empty = (count <= (depth_bits + 1)'(almost_empty_level));

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter
  import arb_ctrl_pkg::*;
#(
  parameter int ports = 6
) (
  input  wire logic               clk,
  input  wire logic               rst_reg,
  input  wire logic [ports-1:0]   request,
  output logic [ports-1:0]        grant,
  output logic                    grant_valid,
  output port_idx_t               grant_encoded
);

  port_idx_t pointer;  // Port with the highest priority this cycle

  // Search starts at the pointer and wraps around past the last port
  always_comb begin
    int idx;
    grant = '0;
    grant_valid = 1'b0;
    grant_encoded = '0;
    for (int i = 0; i < ports; i++) begin
      idx = int'(pointer) + i;
      if (idx >= ports) begin
        idx = idx - ports;
      end
      if (!grant_valid && request[idx]) begin
        grant[idx] = 1'b1;
        grant_valid = 1'b1;
        grant_encoded = port_idx_t'(idx);
      end
    end
  end

  // ########################################
  // Priority rotation
  // ########################################

  // The granted port drops to lowest priority
  always_ff @(posedge clk) begin
    if (rst_reg) begin
      pointer <= '0;
    end else if (grant_valid) begin
      if (grant_encoded == port_idx_t'(ports - 1)) begin
        pointer <= '0;
      end else begin
        pointer <= grant_encoded + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/req_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_ctrl_settings.svh"

module req_select
  import arb_ctrl_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  rst_reg,
  input  wire logic [`ARB_CTRL_PORTS-1:0]            in_valid,
  input  wire req_word_t [`ARB_CTRL_PORTS-1:0]       in_data,
  output logic                                       out_valid,
  output tagged_req_t                                out
);

  tagged_req_t sel;

  // Only one input FIFO is read per cycle, so an AND-OR mux picks the word
  always_comb begin
    sel = '0;
    for (int i = 0; i < `ARB_CTRL_PORTS; i++) begin
      if (in_valid[i]) begin
        sel.src = sel.src | port_idx_t'(i);
        sel.data = sel.data | in_data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out <= sel;
  end

endmodule

`default_nettype wire

//--- source/rd_req_arbiter_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_ctrl_settings.svh"

module rd_req_arbiter_ctrl
  import arb_ctrl_pkg::*;
(
  input  wire logic                              clk,
  input  wire logic                              rst_reg,
  input  wire logic [`ARB_CTRL_PORTS-1:0]        req_wr_en_in,
  input  wire req_word_t [`ARB_CTRL_PORTS-1:0]   req_wr_data_in,
  output logic [`ARB_CTRL_PORTS-1:0]             req_wr_available_in,
  input  wire logic                              req_wr_available_out,
  output logic                                   req_wr_en_out,
  output req_word_t                              req_wr_data_out,
  output port_idx_t                              req_wr_src_out
);

  localparam int ports = `ARB_CTRL_PORTS;
  localparam int in_almost_full_level = 2 ** `ARB_CTRL_IN_DEPTH_BITS - 6;
  localparam int in_almost_empty_level = 4;
  localparam int out_almost_full_level = 2 ** `ARB_CTRL_OUT_DEPTH_BITS - 6;
  localparam int out_almost_empty_level = 2;

  logic [ports-1:0] in_fifo_we;
  req_word_t [ports-1:0] in_fifo_din;
  logic [ports-1:0] in_fifo_re;
  wire logic [ports-1:0] in_fifo_valid;
  wire req_word_t [ports-1:0] in_fifo_dout;
  wire logic [ports-1:0] in_fifo_empty;
  wire logic [ports-1:0] in_fifo_full;
  wire logic [ports-1:0] in_fifo_almost_full;
  wire logic [ports-1:0] in_fifo_almost_empty;

  wire logic select_valid;
  wire tagged_req_t select_out;

  logic out_fifo_we;
  tagged_req_t out_fifo_din;
  logic out_fifo_re;
  wire logic out_fifo_valid;
  wire tagged_req_t out_fifo_dout;
  wire logic out_fifo_empty;
  wire logic out_fifo_full;
  wire logic out_fifo_almost_full;
  wire logic out_fifo_almost_empty;

  logic [ports-1:0] bulk_request;
  wire logic [ports-1:0] bulk_grant;
  wire logic bulk_grant_valid;
  logic [ports-1:0] single_request;
  wire logic [ports-1:0] single_grant;
  wire logic single_grant_valid;
  logic [1:0] re_holdoff;  // Cycles left before the next single grant
  logic single_take;

  // ########################################
  // Input registers and FIFOs
  // ########################################

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      in_fifo_we <= '0;
      req_wr_available_in <= '0;
    end else begin
      in_fifo_we <= req_wr_en_in;
      req_wr_available_in <= ~in_fifo_almost_full;  // Margin of 6 covers the lag
    end
  end

  always_ff @(posedge clk) begin
    in_fifo_din <= req_wr_data_in;
  end

  for (genvar i = 0; i < ports; i++) begin : gen_in_fifo
    req_fifo #(
      .payload_t(req_word_t),
      .depth_bits(`ARB_CTRL_IN_DEPTH_BITS),
      .almost_full_level(in_almost_full_level),
      .almost_empty_level(in_almost_empty_level)
    ) in_fifo (
      .clk(clk),
      .rst_reg(rst_reg),
      .we(in_fifo_we[i]),
      .din(in_fifo_din[i]),
      .re(in_fifo_re[i]),
      .valid(in_fifo_valid[i]),
      .dout(in_fifo_dout[i]),
      .count(),
      .empty(in_fifo_empty[i]),
      .full(in_fifo_full[i]),
      .almost_full(in_fifo_almost_full[i]),
      .almost_empty(in_fifo_almost_empty[i])
    );
  end

  // ########################################
  // Arbitration
  // ########################################

  // A nearly full output FIFO stalls both arbiters
  assign bulk_request = ~in_fifo_almost_empty & {ports{~out_fifo_almost_full}};
  assign single_request = ~in_fifo_empty & {ports{~out_fifo_almost_full}};

  rr_arbiter #(.ports(ports)) bulk_arbiter (
    .clk(clk),
    .rst_reg(rst_reg),
    .request(bulk_request),
    .grant(bulk_grant),
    .grant_valid(bulk_grant_valid),
    .grant_encoded()
  );

  rr_arbiter #(.ports(ports)) single_arbiter (
    .clk(clk),
    .rst_reg(rst_reg),
    .request(single_request),
    .grant(single_grant),
    .grant_valid(single_grant_valid),
    .grant_encoded()
  );

  // The empty flag lags the read, so a single grant waits out two cycles
  assign single_take = !bulk_grant_valid && single_grant_valid && (re_holdoff == 2'd0);

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      in_fifo_re <= '0;
      re_holdoff <= 2'd0;
    end else begin
      if (bulk_grant_valid) begin
        in_fifo_re <= bulk_grant;
      end else if (single_take) begin
        in_fifo_re <= single_grant;
      end else begin
        in_fifo_re <= '0;
      end
      if (single_take) begin
        re_holdoff <= 2'd2;
      end else if (re_holdoff != 2'd0) begin
        re_holdoff <= re_holdoff - 2'd1;
      end
    end
  end

  req_select select (
    .clk(clk),
    .rst_reg(rst_reg),
    .in_valid(in_fifo_valid),
    .in_data(in_fifo_dout),
    .out_valid(select_valid),
    .out(select_out)
  );

  // ########################################
  // Output FIFO and downstream port
  // ########################################

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      out_fifo_we <= 1'b0;
    end else begin
      out_fifo_we <= select_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_fifo_din <= select_out;
  end

  req_fifo #(
    .payload_t(tagged_req_t),
    .depth_bits(`ARB_CTRL_OUT_DEPTH_BITS),
    .almost_full_level(out_almost_full_level),
    .almost_empty_level(out_almost_empty_level)
  ) out_fifo (
    .clk(clk),
    .rst_reg(rst_reg),
    .we(out_fifo_we),
    .din(out_fifo_din),
    .re(out_fifo_re),
    .valid(out_fifo_valid),
    .dout(out_fifo_dout),
    .count(),
    .empty(out_fifo_empty),
    .full(out_fifo_full),
    .almost_full(out_fifo_almost_full),
    .almost_empty(out_fifo_almost_empty)
  );

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      out_fifo_re <= 1'b0;
      req_wr_en_out <= 1'b0;
    end else begin
      // Near empty, reads go one at a time so none is wasted
      if (out_fifo_almost_empty) begin
        out_fifo_re <= req_wr_available_out && !out_fifo_empty && !out_fifo_re;
      end else begin
        out_fifo_re <= req_wr_available_out;
      end
      req_wr_en_out <= out_fifo_valid;
    end
  end

  always_ff @(posedge clk) begin
    req_wr_data_out <= out_fifo_dout.data;
    req_wr_src_out <= out_fifo_dout.src;
  end

endmodule

`default_nettype wire

//--- sim/rd_req_arbiter_ctrl_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module rd_req_arbiter_ctrl_assertions #(
  parameter int ports = 6
) (
  input wire logic             clk,
  input wire logic             rst_reg,
  input wire logic [ports-1:0] request,
  input wire logic [ports-1:0] grant,
  input wire logic             grant_valid,
  input wire logic [ports:0]   fifo_we,    // Input FIFOs plus the output FIFO on top
  input wire logic [ports:0]   fifo_full,
  input wire logic             available_out,
  input wire logic             en_out
);

  int unsigned failures = 0;

  // ########################################
  // Arbiter
  // ########################################

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_reg) $onehot0(grant))
    else begin
      $error("Grant has more than one bit set");
      failures++;
    end

  a_grant_valid: assert property (@(posedge clk) disable iff (rst_reg)
    grant_valid == (|request))
    else begin
      $error("grant_valid does not follow the request vector");
      failures++;
    end

  // ########################################
  // FIFOs and downstream port
  // ########################################

  a_no_overflow: assert property (@(posedge clk) disable iff (rst_reg)
    (fifo_we & fifo_full) == '0)
    else begin
      $error("A full FIFO was written");
      failures++;
    end

  // Two words may still be in flight after available_out falls
  a_out_stops: assert property (@(posedge clk) disable iff (rst_reg)
    (!available_out && $past(!available_out) && $past(!available_out, 2)
     && $past(!available_out, 3)) |-> !en_out)
    else begin
      $error("req_wr_en_out high too long after available_out fell");
      failures++;
    end

endmodule

bind rr_arbiter rd_req_arbiter_ctrl_assertions #(.ports(ports)) arb_checks (
  .clk(clk),
  .rst_reg(rst_reg),
  .request(request),
  .grant(grant),
  .grant_valid(grant_valid),
  .fifo_we('0),
  .fifo_full('0),
  .available_out(1'b1),
  .en_out(1'b0)
);

bind rd_req_arbiter_ctrl rd_req_arbiter_ctrl_assertions #(.ports(ports)) top_checks (
  .clk(clk),
  .rst_reg(rst_reg),
  .request(bulk_request),
  .grant(bulk_grant),
  .grant_valid(bulk_grant_valid),
  .fifo_we({out_fifo_we, in_fifo_we}),
  .fifo_full({out_fifo_full, in_fifo_full}),
  .available_out(req_wr_available_out),
  .en_out(req_wr_en_out)
);

`default_nettype wire

//--- sim/rd_req_arbiter_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "arb_ctrl_settings.svh"

module rd_req_arbiter_ctrl_tb
  import arb_ctrl_pkg::*;
();

  localparam int ports = `ARB_CTRL_PORTS;
  localparam int clk_period = 20;
  localparam int light_cycles = 300;
  localparam int sat_cycles = 200;
  localparam int bp_cycles = 400;
  localparam int max_words = ports * (light_cycles + sat_cycles + bp_cycles + 61);
  localparam int timeout_ns = 4 * max_words * 20 * clk_period;

  logic clk;
  logic rst_reg;
  logic [ports-1:0] req_wr_en_in;
  req_word_t [ports-1:0] req_wr_data_in;
  logic [ports-1:0] req_wr_available_in;
  logic req_wr_available_out;
  logic req_wr_en_out;
  req_word_t req_wr_data_out;
  port_idx_t req_wr_src_out;

  req_word_t model_q [ports][$];  // Words written per port and not yet seen at the output
  int unsigned writes_total = 0;
  int unsigned outputs_total = 0;
  logic sat_check = 1'b0;
  int unsigned sat_outputs = 0;
  port_idx_t recent_src [ports];
  logic bp_active = 1'b0;
  logic [ports-1:0] avail_fell = '0;
  int unsigned low_cycles = 0;
  int unsigned late_words = 0;

  rd_req_arbiter_ctrl UUT (
    .clk(clk),
    .rst_reg(rst_reg),
    .req_wr_en_in(req_wr_en_in),
    .req_wr_data_in(req_wr_data_in),
    .req_wr_available_in(req_wr_available_in),
    .req_wr_available_out(req_wr_available_out),
    .req_wr_en_out(req_wr_en_out),
    .req_wr_data_out(req_wr_data_out),
    .req_wr_src_out(req_wr_src_out)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Stopping after the first error");
  endtask

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s exp %h got %h", name, exp, got));
    end
  endtask

  // ########################################
  // Stimulus
  // ########################################

  // A port writes only while its available bit is high
  task automatic drive_cycle(input int unsigned write_pct);
    req_word_t word;
    @(posedge clk);
    #2;
    for (int i = 0; i < ports; i++) begin
      word = $urandom;
      req_wr_data_in[i] = word;
      req_wr_en_in[i] = req_wr_available_in[i] && ($urandom_range(99) < write_pct);
      if (req_wr_en_in[i]) begin
        model_q[i].push_back(word);
        writes_total++;
      end
    end
  endtask

  // Stops once every write has come out, or once the output has gone quiet
  task automatic drain_outputs();
    int unsigned quiet;
    int unsigned last_count;
    quiet = 0;
    last_count = outputs_total;
    while (outputs_total != writes_total && quiet < 64) begin
      drive_cycle(0);
      if (outputs_total == last_count) begin
        quiet++;
      end else begin
        quiet = 0;
        last_count = outputs_total;
      end
    end
    repeat (20) drive_cycle(0);  // Room for a stray extra word to show up
  endtask

  initial begin : stimulus
    int unsigned settle;
    int unsigned assert_failures;
    void'($urandom(32'h208c));
    rst_reg = 1'b1;
    req_wr_en_in = '0;
    req_wr_data_in = '0;
    req_wr_available_out = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    check_equal("req_wr_en_out", 0, req_wr_en_out);
    check_equal("req_wr_available_in", 0, req_wr_available_in);
    rst_reg = 1'b0;
    settle = 0;
    while (req_wr_available_in != '1) begin
      drive_cycle(0);
      settle++;
      if (settle > 8) begin
        abort_run("req_wr_available_in did not rise after reset");
      end
    end

    repeat (light_cycles) drive_cycle(12);
    drain_outputs();

    sat_check = 1'b1;  // Every port writes whenever it can
    repeat (sat_cycles) drive_cycle(100);
    sat_check = 1'b0;
    if (sat_outputs < 12 + 4 * ports) begin
      abort_run("Too few outputs during the saturation phase");
    end
    drain_outputs();

    bp_active = 1'b1;
    drive_cycle(100);
    req_wr_available_out = 1'b0;
    repeat (60) drive_cycle(100);
    repeat (bp_cycles) begin
      drive_cycle(50);
      if ($urandom_range(99) < 20) begin
        req_wr_available_out = ~req_wr_available_out;
      end
    end
    bp_active = 1'b0;
    check_equal("req_wr_available_in_fell", {ports{1'b1}}, avail_fell);
    drive_cycle(0);
    req_wr_available_out = 1'b1;
    drain_outputs();

    for (int i = 0; i < ports; i++) begin
      check_equal($sformatf("model_q[%0d].size", i), 0, model_q[i].size());
    end
    check_equal("output_word_count", writes_total, outputs_total);
    assert_failures = UUT.top_checks.failures + UUT.bulk_arbiter.arb_checks.failures
                      + UUT.single_arbiter.arb_checks.failures;
    if (assert_failures == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      abort_run($sformatf("%0d assertion failures were reported", assert_failures));
    end
  end

  // ########################################
  // Output monitor
  // ########################################

  always @(negedge clk) begin : output_monitor
    req_word_t expected;
    logic [ports-1:0] window;
    if (!rst_reg) begin
      if (bp_active) begin
        avail_fell = avail_fell | ~req_wr_available_in;
      end
      if (!req_wr_available_out) begin
        low_cycles++;
      end else begin
        low_cycles = 0;
        late_words = 0;
      end
      if (req_wr_en_out) begin
        if (low_cycles >= 2) begin
          late_words++;  // Arrived after the cycle in which available_out fell
        end
        if (late_words > 2) begin
          abort_run("More than 2 words arrived after req_wr_available_out fell");
        end
        if (int'(req_wr_src_out) >= ports) begin
          abort_run($sformatf("Output word names port %0d, which does not exist",
                              req_wr_src_out));
        end
        if (model_q[req_wr_src_out].size() == 0) begin
          abort_run($sformatf("Output word from port %0d with no pending request",
                              req_wr_src_out));
        end
        expected = model_q[req_wr_src_out].pop_front();
        check_equal("req_wr_data_out", expected, req_wr_data_out);
        outputs_total++;
        if (sat_check) begin
          for (int k = ports - 1; k > 0; k--) begin
            recent_src[k] = recent_src[k-1];
          end
          recent_src[0] = req_wr_src_out;
          sat_outputs++;
          // Only the bulk arbiter grants once every input FIFO is well filled
          if (sat_outputs >= 12 + ports) begin
            window = '0;
            for (int k = 0; k < ports; k++) begin
              window[recent_src[k]] = 1'b1;
            end
            check_equal("req_wr_src_out_window", {ports{1'b1}}, window);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    abort_run("Timeout: the run did not finish in the expected time");
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/arb_ctrl_pkg.sv
source/req_fifo.sv
source/rr_arbiter.sv
source/req_select.sv
source/rd_req_arbiter_ctrl.sv
sim/rd_req_arbiter_ctrl_assertions.sv
sim/rd_req_arbiter_ctrl_tb.sv

//--- Bender.yml
package:
  name: rd_req_arbiter_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/arb_ctrl_pkg.sv
      - source/req_fifo.sv
      - source/rr_arbiter.sv
      - source/req_select.sv
      - source/rd_req_arbiter_ctrl.sv

  - target: test
    include_dirs:
      - source
    files:
      - sim/rd_req_arbiter_ctrl_assertions.sv
      - sim/rd_req_arbiter_ctrl_tb.sv
